// File: Makefile
# Verilator flow for the ADC receiver testbench

TB_TOP = adc_lvds_rx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP)

clean:
	rm -rf obj_dir

// File: all.f
verilog/adc_rx_pkg.sv
verilog/adc_bus_if.sv
verilog/frame_aligner.sv
verilog/channel_deser.sv
verilog/sample_output.sv
verilog/adc_lvds_rx.sv
verif/tb_clock_gen.sv
verif/adc_lvds_rx_sva.sv
verif/adc_lvds_rx_tb.sv

// File: verif/adc_lvds_rx_sva.sv
`timescale 1ns/1ps

module adc_lvds_rx_sva (
  input logic                            dclk,
  input logic                            arst_n,
  input logic [adc_rx_pkg::adc_bits-1:0] sample_ch0,
  input logic [adc_rx_pkg::adc_bits-1:0] sample_ch1,
  input logic [adc_rx_pkg::adc_bits-1:0] sample_ch2,
  input logic [adc_rx_pkg::adc_bits-1:0] sample_ch3,
  input logic                            sample_valid,
  input logic                            locked,
  input logic                            bitslip
);

  // ------------------------------------------------------------------------
  // Lock related rules
  // ------------------------------------------------------------------------

  // Valid only for frames taken while aligned
  valid_needs_lock : assert property (@(posedge dclk) disable iff (!arst_n)
    $rose(sample_valid) |-> locked)
    else $error("sample_valid rose while locked was low");

  // A slip always comes with loss of lock
  slip_needs_unlock : assert property (@(posedge dclk) disable iff (!arst_n)
    $rose(bitslip) |-> !locked)
    else $error("bitslip rose while locked was high");

  // ------------------------------------------------------------------------
  // Reset values
  // ------------------------------------------------------------------------

  outputs_low_in_reset : assert property (@(posedge dclk)
    !arst_n |-> (!sample_valid && !locked && !bitslip &&
                 sample_ch0 == '0 && sample_ch1 == '0 &&
                 sample_ch2 == '0 && sample_ch3 == '0))
    else $error("outputs not cleared during reset");

endmodule

// File: verif/adc_lvds_rx_tb.sv
`timescale 1ns/1ps

module adc_lvds_rx_tb;

  localparam int fbits        = adc_rx_pkg::frame_bits;
  localparam int lock_trials  = 4;
  localparam int lock_limit   = 12;
  localparam int data_frames  = 8;
  // Lock bound in cycles from the release of reset
  localparam int lock_bound   = (fbits + adc_rx_pkg::lock_frames) * fbits + fbits;
  localparam int total_frames = lock_trials * (lock_limit + 2) +
                                3 * (data_frames + 1) + 2 + lock_limit;
  localparam int timeout_ns   = total_frames * fbits * 4 + 2000;

  localparam logic [47:0] filler = 48'h0;

  logic       dclk;
  logic       arst_n;
  logic       fclk;
  logic [7:0] data_lane;
  logic       byte_mode;
  logic [11:0] sample_ch0;
  logic [11:0] sample_ch1;
  logic [11:0] sample_ch2;
  logic [11:0] sample_ch3;
  logic       sample_valid;
  logic       locked;
  logic       bitslip;

  int          seed = 81424;
  logic [47:0] sent_q[$];
  bit          strict;
  int          cyc = 0;
  bit          lock_seen;
  int          lock_cyc;

  tb_clock_gen clock_gen_i (
    .dclk (dclk)
  );

  adc_lvds_rx adc_lvds_rx_i (
    .dclk         (dclk),
    .arst_n       (arst_n),
    .fclk         (fclk),
    .data_lane    (data_lane),
    .byte_mode    (byte_mode),
    .sample_ch0   (sample_ch0),
    .sample_ch1   (sample_ch1),
    .sample_ch2   (sample_ch2),
    .sample_ch3   (sample_ch3),
    .sample_valid (sample_valid),
    .locked       (locked),
    .bitslip      (bitslip)
  );

  bind adc_lvds_rx adc_lvds_rx_sva adc_lvds_rx_sva_i (
    .dclk         (dclk),
    .arst_n       (arst_n),
    .sample_ch0   (sample_ch0),
    .sample_ch1   (sample_ch1),
    .sample_ch2   (sample_ch2),
    .sample_ch3   (sample_ch3),
    .sample_valid (sample_valid),
    .locked       (locked),
    .bitslip      (bitslip)
  );

  // ------------------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [47:0] exp,
                             input logic [47:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s expected %h got %h", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  task automatic reset_dut();
    @(negedge dclk);
    arst_n    = 1'b0;
    fclk      = 1'b0;
    data_lane = '0;
    strict    = 1'b0;
    lock_seen = 1'b0;
    sent_q.delete();
    repeat (5) @(negedge dclk);
    arst_n = 1'b1;
  endtask

  // Channel c sits in frame bits 47-12c downwards and goes out MSB first
  task automatic send_frame(input logic [47:0] frame, input logic [5:0] fpat);
    logic [11:0] s;
    for (int j = 0; j < fbits; j++) begin
      @(negedge dclk);
      fclk = fpat[5-j];
      for (int c = 0; c < 4; c++) begin
        s = frame[47-12*c -: 12];
        if (byte_mode) begin
          data_lane[2*c]   = s[11-j];
          data_lane[2*c+1] = s[5-j];
        end else begin
          data_lane[2*c]   = s[11-2*j];
          data_lane[2*c+1] = s[10-2*j];
        end
      end
    end
    sent_q.push_back(frame);
  endtask

  task automatic acquire_lock(input int limit);
    int n;
    n = 0;
    while (!locked && n < limit) begin
      send_frame(filler, adc_rx_pkg::frame_pattern);
      n++;
    end
    if (!locked) begin
      fail_run($sformatf("no lock after %0d frames", limit));
    end
  endtask

  // Only the frame still in flight stays pending
  task automatic enter_strict();
    while (sent_q.size() > 1) begin
      void'(sent_q.pop_front());
    end
    strict = 1'b1;
  endtask

  task automatic leave_strict();
    send_frame(filler, adc_rx_pkg::frame_pattern);
    check_value("frames_pending", 48'(1), 48'(sent_q.size()));
    strict = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------------------

  always @(posedge dclk) begin
    cyc <= cyc + 1;
  end

  always @(negedge dclk) begin : monitor
    logic [47:0] exp_frame;
    if (arst_n && locked && !lock_seen) begin
      lock_seen = 1'b1;
      lock_cyc  = cyc;
    end
    if (arst_n && strict && bitslip) begin
      fail_run("bitslip pulsed while lock was held");
    end
    if (arst_n && sample_valid) begin
      if (!locked) begin
        fail_run("sample_valid pulsed while locked was low");
      end
      if (sent_q.size() == 0) begin
        fail_run("sample_valid pulsed with no frame sent");
      end
      if (strict) begin
        check_value("frames_pending", 48'(1), 48'(sent_q.size()));
      end
      exp_frame = sent_q[$];
      check_value("sample_ch0", 48'(exp_frame[47:36]), 48'(sample_ch0));
      check_value("sample_ch1", 48'(exp_frame[35:24]), 48'(sample_ch1));
      check_value("sample_ch2", 48'(exp_frame[23:12]), 48'(sample_ch2));
      check_value("sample_ch3", 48'(exp_frame[11:0]), 48'(sample_ch3));
      sent_q.delete();
    end
  end

  // ------------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------------

  task automatic test_reset_state();
    reset_dut();
    @(negedge dclk);
    check_value("bitslip", 48'(0), 48'(bitslip));
    repeat (20) begin
      @(negedge dclk);
      check_value("sample_valid", 48'(0), 48'(sample_valid));
      check_value("locked", 48'(0), 48'(locked));
      check_value("samples", 48'(0),
                  {sample_ch0, sample_ch1, sample_ch2, sample_ch3});
    end
  endtask

  task automatic test_lock();
    int offset;
    int start_cyc;
    for (int t = 0; t < lock_trials; t++) begin
      offset = $unsigned($random(seed)) % fbits;
      reset_dut();
      start_cyc = cyc;
      repeat (offset) @(negedge dclk);
      acquire_lock(lock_limit);
      if (lock_cyc - start_cyc > lock_bound) begin
        fail_run($sformatf("lock took %0d cycles, bound is %0d",
                           lock_cyc - start_cyc, lock_bound));
      end
      enter_strict();
      send_frame(filler, adc_rx_pkg::frame_pattern);
      leave_strict();
    end
  endtask

  task automatic test_decode(input logic mode);
    logic [11:0] patt [4];
    logic [47:0] frame;
    patt[0] = 12'h000;
    patt[1] = 12'hFFF;
    patt[2] = 12'hAAA;
    patt[3] = 12'h555;
    byte_mode = mode;
    enter_strict();
    // Each channel gets every directed value once
    for (int i = 0; i < 4; i++) begin
      frame = {patt[i%4], patt[(i+1)%4], patt[(i+2)%4], patt[(i+3)%4]};
      send_frame(frame, adc_rx_pkg::frame_pattern);
    end
    for (int i = 4; i < data_frames; i++) begin
      frame = {12'($random(seed)), 12'($random(seed)),
               12'($random(seed)), 12'($random(seed))};
      send_frame(frame, adc_rx_pkg::frame_pattern);
    end
    leave_strict();
  endtask

  task automatic test_lock_loss();
    send_frame(filler, 6'b101010);
    send_frame(filler, adc_rx_pkg::frame_pattern);
    check_value("locked", 48'(0), 48'(locked));
    acquire_lock(lock_limit);
    test_decode(1'b0);
  endtask

  // ------------------------------------------------------------------------
  // Watchdog and main sequence
  // ------------------------------------------------------------------------

  initial begin
    #(timeout_ns);
    fail_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    arst_n    = 1'b1;
    fclk      = 1'b0;
    data_lane = '0;
    byte_mode = 1'b0;
    strict    = 1'b0;
    lock_seen = 1'b0;
    lock_cyc  = 0;
    test_reset_state();
    test_lock();
    test_decode(1'b0);
    test_decode(1'b1);
    test_lock_loss();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic dclk
);

  localparam realtime half_period = 2ns;

  // Starts high so the first edge is a falling one
  initial begin
    dclk = 1'b1;
  end

  always #(half_period) dclk = ~dclk;

endmodule

// File: verilog/adc_bus_if.sv
`timescale 1ns/1ps

interface adc_bus_if (
  input logic dclk
);

  // Frame timing from the aligner
  logic word_strobe;
  logic locked;

  // One rebuilt word and load pulse per channel
  logic [adc_rx_pkg::adc_bits-1:0] chan_word [adc_rx_pkg::num_chans];
  logic                            chan_load [adc_rx_pkg::num_chans];

  modport aligner (
    input  dclk,
    output word_strobe,
    output locked
  );

  // Each channel writes only its own element of chan_word and chan_load
  modport channel (
    input  dclk,
    input  word_strobe,
    output chan_word,
    output chan_load
  );

  modport sink (
    input dclk,
    input word_strobe,
    input locked,
    input chan_word,
    input chan_load
  );

endinterface

// File: verilog/adc_lvds_rx.sv
`timescale 1ns/1ps

module adc_lvds_rx (
  input  logic                             dclk,
  input  logic                             arst_n,
  input  logic                             fclk,
  input  logic [adc_rx_pkg::num_lanes-1:0] data_lane,
  input  logic                             byte_mode,
  output logic [adc_rx_pkg::adc_bits-1:0]  sample_ch0,
  output logic [adc_rx_pkg::adc_bits-1:0]  sample_ch1,
  output logic [adc_rx_pkg::adc_bits-1:0]  sample_ch2,
  output logic [adc_rx_pkg::adc_bits-1:0]  sample_ch3,
  output logic                             sample_valid,
  output logic                             locked,
  output logic                             bitslip
);

  adc_bus_if bus_i (
    .dclk (dclk)
  );

  // ------------------------------------------------------------------------
  // Frame alignment
  // ------------------------------------------------------------------------

  frame_aligner frame_aligner_i (
    .dclk    (dclk),
    .arst_n  (arst_n),
    .fclk    (fclk),
    .bus     (bus_i.aligner),
    .bitslip (bitslip)
  );

  assign locked = bus_i.locked;

  // ------------------------------------------------------------------------
  // Channels
  // ------------------------------------------------------------------------

  // Channel c uses lanes 2c and 2c+1
  for (genvar c = 0; c < adc_rx_pkg::num_chans; c++) begin : g_chan
    channel_deser #(
      .chan_idx (c)
    ) channel_deser_i (
      .dclk      (dclk),
      .arst_n    (arst_n),
      .lanes     (data_lane[2*c +: 2]),
      .byte_mode (byte_mode),
      .bus       (bus_i.channel)
    );
  end

  // ------------------------------------------------------------------------
  // Output stage
  // ------------------------------------------------------------------------

  sample_output sample_output_i (
    .dclk         (dclk),
    .arst_n       (arst_n),
    .bus          (bus_i.sink),
    .sample_ch0   (sample_ch0),
    .sample_ch1   (sample_ch1),
    .sample_ch2   (sample_ch2),
    .sample_ch3   (sample_ch3),
    .sample_valid (sample_valid)
  );

endmodule

// File: verilog/adc_rx_pkg.sv
package adc_rx_pkg;

  // ------------------------------------------------------------------------
  // Sample and lane geometry
  // ------------------------------------------------------------------------

  // Sample width of one ADC channel
  localparam int adc_bits = 12;

  // Two-wire mode, so each channel uses a pair of lanes
  localparam int wire_mode = 2;
  localparam int num_chans = 4;
  localparam int num_lanes = num_chans * wire_mode;

  // Bits per lane in one frame
  localparam int frame_bits = adc_bits / wire_mode;

  // ------------------------------------------------------------------------
  // Frame alignment
  // ------------------------------------------------------------------------

  // Frame clock as seen bit by bit, first received bit on the left
  localparam logic [frame_bits-1:0] frame_pattern = 6'b111000;

  // Good frames in a row before the receiver reports lock
  localparam int lock_frames = 2;

  // Bit position counter
  localparam int cnt_width = $clog2(frame_bits);
  localparam logic [cnt_width-1:0] cnt_last = cnt_width'(frame_bits - 1);

  // Match counter, saturates at lock_frames
  localparam int match_width = $clog2(lock_frames + 1);
  localparam logic [match_width-1:0] match_lock = match_width'(lock_frames);

endpackage

// File: verilog/channel_deser.sv
`timescale 1ns/1ps

module channel_deser #(
  parameter int unsigned chan_idx = 0
) (
  input  logic       dclk,
  input  logic       arst_n,
  input  logic [1:0] lanes,
  input  logic       byte_mode,
  adc_bus_if.channel bus
);

  // Per-lane shift registers, first received bit ends up at the MSB
  logic [adc_rx_pkg::frame_bits-1:0] lane0_sr;
  logic [adc_rx_pkg::frame_bits-1:0] lane1_sr;

  logic [adc_rx_pkg::adc_bits-1:0] sample_next;

  // ------------------------------------------------------------------------
  // Lane capture
  // ------------------------------------------------------------------------

  always_ff @(posedge dclk) begin
    lane0_sr <= {lane0_sr[adc_rx_pkg::frame_bits-2:0], lanes[0]};
    lane1_sr <= {lane1_sr[adc_rx_pkg::frame_bits-2:0], lanes[1]};
  end

  // ------------------------------------------------------------------------
  // Lane order swap
  // ------------------------------------------------------------------------

  // Byte mode splits the sample into an upper and a lower half.
  // Bit mode interleaves the lanes, lane 0 with the odd bits.
  always_comb begin
    sample_next = '0;
    if (byte_mode) begin
      sample_next = {lane0_sr, lane1_sr};
    end else begin
      for (int i = 0; i < adc_rx_pkg::frame_bits; i++) begin
        sample_next[2*i+1] = lane0_sr[i];
        sample_next[2*i]   = lane1_sr[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Word register
  // ------------------------------------------------------------------------

  // Strobe is high the cycle after the last bit, when the shift
  // registers still hold the complete frame
  always_ff @(posedge dclk) begin
    if (bus.word_strobe) begin
      bus.chan_word[chan_idx] <= sample_next;
    end
  end

  always_ff @(posedge dclk or negedge arst_n) begin
    if (!arst_n) begin
      bus.chan_load[chan_idx] <= 1'b0;
    end else begin
      bus.chan_load[chan_idx] <= bus.word_strobe;
    end
  end

endmodule

// File: verilog/frame_aligner.sv
`timescale 1ns/1ps

module frame_aligner (
  input  logic            dclk,
  input  logic            arst_n,
  input  logic            fclk,
  adc_bus_if.aligner      bus,
  output logic            bitslip
);

  // Bit position inside the current frame
  logic [adc_rx_pkg::cnt_width-1:0] bit_cnt;

  // Earlier frame clock bits with the newest on the right
  logic [adc_rx_pkg::frame_bits-2:0] fclk_sr;

  // Good frames seen in a row
  logic [adc_rx_pkg::match_width-1:0] match_cnt;

  logic                              last_bit;
  logic [adc_rx_pkg::frame_bits-1:0] frame_now;
  logic                              frame_ok;

  // ------------------------------------------------------------------------
  // Frame clock capture
  // ------------------------------------------------------------------------

  always_ff @(posedge dclk) begin
    fclk_sr <= {fclk_sr[adc_rx_pkg::frame_bits-3:0], fclk};
  end

  // The last bit of the frame comes straight from fclk on this edge
  assign last_bit  = (bit_cnt == adc_rx_pkg::cnt_last) && !bitslip;
  assign frame_now = {fclk_sr, fclk};
  assign frame_ok  = (frame_now == adc_rx_pkg::frame_pattern);

  // ------------------------------------------------------------------------
  // Bit counter
  // ------------------------------------------------------------------------

  // A slip holds the counter one cycle and so moves the frame boundary
  // one bit later in the stream
  always_ff @(posedge dclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (bitslip) begin
      bit_cnt <= bit_cnt;
    end else if (last_bit) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Pattern check, slip and lock
  // ------------------------------------------------------------------------

  always_ff @(posedge dclk or negedge arst_n) begin
    if (!arst_n) begin
      bus.word_strobe <= 1'b0;
      bus.locked      <= 1'b0;
      bitslip         <= 1'b0;
      match_cnt       <= '0;
    end else begin
      bus.word_strobe <= last_bit;
      bitslip         <= 1'b0;
      if (last_bit) begin
        if (frame_ok) begin
          if (match_cnt != adc_rx_pkg::match_lock) begin
            match_cnt <= match_cnt + 1'b1;
          end
          // Lock on the strobe of the last required good frame
          if (match_cnt >= adc_rx_pkg::match_lock - 1'b1) begin
            bus.locked <= 1'b1;
          end
        end else begin
          match_cnt  <= '0;
          bus.locked <= 1'b0;
          bitslip    <= 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/sample_output.sv
`timescale 1ns/1ps

module sample_output (
  input  logic                            dclk,
  input  logic                            arst_n,
  adc_bus_if.sink                         bus,
  output logic [adc_rx_pkg::adc_bits-1:0] sample_ch0,
  output logic [adc_rx_pkg::adc_bits-1:0] sample_ch1,
  output logic [adc_rx_pkg::adc_bits-1:0] sample_ch2,
  output logic [adc_rx_pkg::adc_bits-1:0] sample_ch3,
  output logic                            sample_valid
);

  logic all_loaded;

  // Channels load together, so wait for every one of them
  always_comb begin
    all_loaded = 1'b1;
    for (int c = 0; c < adc_rx_pkg::num_chans; c++) begin
      all_loaded = all_loaded & bus.chan_load[c];
    end
  end

  // ------------------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------------------

  // Samples are held between frames; the valid pulse is
  // only given for frames taken while locked
  always_ff @(posedge dclk or negedge arst_n) begin
    if (!arst_n) begin
      sample_ch0   <= '0;
      sample_ch1   <= '0;
      sample_ch2   <= '0;
      sample_ch3   <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (all_loaded) begin
        sample_ch0   <= bus.chan_word[0];
        sample_ch1   <= bus.chan_word[1];
        sample_ch2   <= bus.chan_word[2];
        sample_ch3   <= bus.chan_word[3];
        sample_valid <= bus.locked;
      end
    end
  end

endmodule
